// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = line_coder_tb
FILELIST = files.f
OBJ_DIR  = obj_dir
PASS_MSG = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
rtl/line_code_pkg.sv
rtl/encode_8b10b.sv
rtl/decode_8b10b.sv
rtl/line_coder.sv
verification/line_coder_assert.sv
verification/line_coder_tb.sv

// File: rtl/decode_8b10b.sv
`timescale 1ns/100ps

module decode_8b10b import line_code_pkg::*; (
	input logic clk,
	input logic arst_n,
	input codeword_t rx_code,
	output rx_symbol_t rx_sym,
	output logic rx_disp_neg
);

	// 6b/5b results
	logic [4:0] five_b;
	logic six_valid;
	logic six_k28;
	// 6b codes allowed ahead of K.x.7
	logic six_k7_ok;
	// 6b codes allowed ahead of D.x.A7
	logic six_a7_ok;

	// 4b/3b results
	logic [3:0] four_lookup;
	logic [2:0] three_b;
	logic four_valid;
	logic four_alt7;

	// Disparity check
	logic [2:0] six_ones;
	logic [2:0] four_ones;
	logic six_derr;
	logic four_derr;
	logic mid_neg;
	logic end_neg;
	rx_symbol_t sym_nxt;

	// Returns {error, disparity after sub-block}
	function automatic logic [1:0] check_disp(
		input logic [2:0] ones,
		input logic [2:0] half,
		input logic alt_neg,
		input logic alt_pos,
		input logic rd_neg
	);
		logic err;
		logic rd_after;
		err = 1'b0;
		rd_after = rd_neg;
		if (ones > half) begin
			// Positive group needs negative disparity first
			err = ~rd_neg;
			rd_after = 1'b0;
		end else if (ones < half) begin
			err = rd_neg;
			rd_after = 1'b1;
		end else if (alt_neg) begin
			// Alternating neutral pair, disparity holds
			err = ~rd_neg;
			rd_after = 1'b1;
		end else if (alt_pos) begin
			err = rd_neg;
			rd_after = 1'b0;
		end
		return {err, rd_after};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// 6b/5b table

	always_comb begin
		six_valid = 1'b1;
		case (rx_code.sb.six_b)
			6'b100111, 6'b011000: five_b = 5'd0;
			6'b011101, 6'b100010: five_b = 5'd1;
			6'b101101, 6'b010010: five_b = 5'd2;
			6'b110001: five_b = 5'd3;
			6'b110101, 6'b001010: five_b = 5'd4;
			6'b101001: five_b = 5'd5;
			6'b011001: five_b = 5'd6;
			6'b111000, 6'b000111: five_b = 5'd7;
			6'b111001, 6'b000110: five_b = 5'd8;
			6'b100101: five_b = 5'd9;
			6'b010101: five_b = 5'd10;
			6'b110100: five_b = 5'd11;
			6'b001101: five_b = 5'd12;
			6'b101100: five_b = 5'd13;
			6'b011100: five_b = 5'd14;
			6'b010111, 6'b101000: five_b = 5'd15;
			6'b011011, 6'b100100: five_b = 5'd16;
			6'b100011: five_b = 5'd17;
			6'b010011: five_b = 5'd18;
			6'b110010: five_b = 5'd19;
			6'b001011: five_b = 5'd20;
			6'b101010: five_b = 5'd21;
			6'b011010: five_b = 5'd22;
			6'b111010, 6'b000101: five_b = 5'd23;
			6'b110011, 6'b001100: five_b = 5'd24;
			6'b100110: five_b = 5'd25;
			6'b010110: five_b = 5'd26;
			6'b110110, 6'b001001: five_b = 5'd27;
			// D28 plus both K28 groups
			6'b001110, 6'b001111, 6'b110000: five_b = 5'd28;
			6'b101110, 6'b010001: five_b = 5'd29;
			6'b011110, 6'b100001: five_b = 5'd30;
			6'b101011, 6'b010100: five_b = 5'd31;
			default: begin
				five_b = 5'd0;
				six_valid = 1'b0;
			end
		endcase
	end

	assign six_k28 = (rx_code.sb.six_b == 6'b001111) || (rx_code.sb.six_b == 6'b110000);
	assign six_k7_ok = six_valid && (five_b inside {5'd23, 5'd27, 5'd29, 5'd30});
	assign six_a7_ok = six_valid && (five_b inside {5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20});

	//////////////////////////////////////////////////////////////////////
	// 4b/3b table

	// Negative K28 swaps balanced 4b codes, undo it before lookup
	assign four_lookup = (rx_code.sb.six_b == 6'b110000) ? ~rx_code.sb.four_b
		: rx_code.sb.four_b;

	always_comb begin
		four_valid = 1'b1;
		four_alt7 = 1'b0;
		case (four_lookup)
			4'b1011, 4'b0100: three_b = 3'd0;
			4'b1001: three_b = 3'd1;
			4'b0101: three_b = 3'd2;
			4'b1100, 4'b0011: three_b = 3'd3;
			4'b1101, 4'b0010: three_b = 3'd4;
			4'b1010: three_b = 3'd5;
			4'b0110: three_b = 3'd6;
			4'b1110, 4'b0001: three_b = 3'd7;
			4'b0111, 4'b1000: begin
				// A7 or K.x.7, told apart by the 6b part
				three_b = 3'd7;
				four_alt7 = 1'b1;
			end
			default: begin
				three_b = 3'd0;
				four_valid = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Disparity and error checks

	assign six_ones = 3'($countones(rx_code.sb.six_b));
	assign four_ones = 3'($countones(rx_code.sb.four_b));

	always_comb begin
		{six_derr, mid_neg} = check_disp(six_ones, 3'd3, rx_code.sb.six_b == 6'b111000,
			rx_code.sb.six_b == 6'b000111, rx_disp_neg);
		// 4b judged against disparity left by 6b
		{four_derr, end_neg} = check_disp(four_ones, 3'd2, rx_code.sb.four_b == 4'b1100,
			rx_code.sb.four_b == 4'b0011, mid_neg);
	end

	always_comb begin
		sym_nxt.is_ctl = six_k28 || (six_k7_ok && four_alt7);
		sym_nxt.data = {three_b, five_b};
		// Alternate 7 behind any other 6b group is illegal
		sym_nxt.code_err = !six_valid || !four_valid
			|| (four_alt7 && !(six_a7_ok || six_k7_ok || six_k28));
		sym_nxt.disp_err = (six_derr && six_valid) || (four_derr && four_valid);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_sym <= '0;
			rx_disp_neg <= 1'b1;
		end else begin
			rx_sym <= sym_nxt;
			// Follows the word even after an error
			rx_disp_neg <= end_neg;
		end
	end

endmodule

// File: rtl/encode_8b10b.sv
`timescale 1ns/100ps

module encode_8b10b import line_code_pkg::*; (
	input logic clk,
	input logic arst_n,
	input tx_symbol_t tx_sym,
	input logic force_disp_neg,
	output codeword_t tx_code,
	output logic tx_disp_neg
);

	// Byte split into its two coding parts
	logic [4:0] five_b;
	logic [2:0] three_b;

	// 6b candidates for each running disparity
	logic [5:0] six_if_neg;
	logic [5:0] six_if_pos;
	// 6b code is unbalanced
	logic six_flip;

	// 4b candidates, indexed by disparity at the 4b position
	logic [3:0] four_if_neg;
	logic [3:0] four_if_pos;
	logic four_flip;

	// Disparity used for this symbol
	logic start_neg;
	logic disp_flip;
	codeword_t code_nxt;

	assign five_b = tx_sym.data[4:0];
	assign three_b = tx_sym.data[7:5];

	//////////////////////////////////////////////////////////////////////
	// 5b/6b table

	always_comb begin
		// Unknown K slots give an all zero group
		{six_if_neg, six_if_pos, six_flip} = {6'b000000, 6'b000000, 1'b1};
		if (tx_sym.is_ctl) begin
			// Only these five 5b values carry a K code
			case (five_b)
				5'd23: {six_if_neg, six_if_pos, six_flip} = {6'b111010, 6'b000101, 1'b1};
				5'd27: {six_if_neg, six_if_pos, six_flip} = {6'b110110, 6'b001001, 1'b1};
				5'd28: {six_if_neg, six_if_pos, six_flip} = {6'b001111, 6'b110000, 1'b1};
				5'd29: {six_if_neg, six_if_pos, six_flip} = {6'b101110, 6'b010001, 1'b1};
				5'd30: {six_if_neg, six_if_pos, six_flip} = {6'b011110, 6'b100001, 1'b1};
				default: ;
			endcase
		end else begin
			case (five_b)
				5'd0: {six_if_neg, six_if_pos, six_flip} = {6'b100111, 6'b011000, 1'b1};
				5'd1: {six_if_neg, six_if_pos, six_flip} = {6'b011101, 6'b100010, 1'b1};
				5'd2: {six_if_neg, six_if_pos, six_flip} = {6'b101101, 6'b010010, 1'b1};
				5'd3: {six_if_neg, six_if_pos, six_flip} = {6'b110001, 6'b110001, 1'b0};
				5'd4: {six_if_neg, six_if_pos, six_flip} = {6'b110101, 6'b001010, 1'b1};
				5'd5: {six_if_neg, six_if_pos, six_flip} = {6'b101001, 6'b101001, 1'b0};
				5'd6: {six_if_neg, six_if_pos, six_flip} = {6'b011001, 6'b011001, 1'b0};
				// Balanced but still alternates
				5'd7: {six_if_neg, six_if_pos, six_flip} = {6'b111000, 6'b000111, 1'b0};
				5'd8: {six_if_neg, six_if_pos, six_flip} = {6'b111001, 6'b000110, 1'b1};
				5'd9: {six_if_neg, six_if_pos, six_flip} = {6'b100101, 6'b100101, 1'b0};
				5'd10: {six_if_neg, six_if_pos, six_flip} = {6'b010101, 6'b010101, 1'b0};
				5'd11: {six_if_neg, six_if_pos, six_flip} = {6'b110100, 6'b110100, 1'b0};
				5'd12: {six_if_neg, six_if_pos, six_flip} = {6'b001101, 6'b001101, 1'b0};
				5'd13: {six_if_neg, six_if_pos, six_flip} = {6'b101100, 6'b101100, 1'b0};
				5'd14: {six_if_neg, six_if_pos, six_flip} = {6'b011100, 6'b011100, 1'b0};
				5'd15: {six_if_neg, six_if_pos, six_flip} = {6'b010111, 6'b101000, 1'b1};
				5'd16: {six_if_neg, six_if_pos, six_flip} = {6'b011011, 6'b100100, 1'b1};
				5'd17: {six_if_neg, six_if_pos, six_flip} = {6'b100011, 6'b100011, 1'b0};
				5'd18: {six_if_neg, six_if_pos, six_flip} = {6'b010011, 6'b010011, 1'b0};
				5'd19: {six_if_neg, six_if_pos, six_flip} = {6'b110010, 6'b110010, 1'b0};
				5'd20: {six_if_neg, six_if_pos, six_flip} = {6'b001011, 6'b001011, 1'b0};
				5'd21: {six_if_neg, six_if_pos, six_flip} = {6'b101010, 6'b101010, 1'b0};
				5'd22: {six_if_neg, six_if_pos, six_flip} = {6'b011010, 6'b011010, 1'b0};
				5'd23: {six_if_neg, six_if_pos, six_flip} = {6'b111010, 6'b000101, 1'b1};
				5'd24: {six_if_neg, six_if_pos, six_flip} = {6'b110011, 6'b001100, 1'b1};
				5'd25: {six_if_neg, six_if_pos, six_flip} = {6'b100110, 6'b100110, 1'b0};
				5'd26: {six_if_neg, six_if_pos, six_flip} = {6'b010110, 6'b010110, 1'b0};
				5'd27: {six_if_neg, six_if_pos, six_flip} = {6'b110110, 6'b001001, 1'b1};
				// D28 differs from K28 here
				5'd28: {six_if_neg, six_if_pos, six_flip} = {6'b001110, 6'b001110, 1'b0};
				5'd29: {six_if_neg, six_if_pos, six_flip} = {6'b101110, 6'b010001, 1'b1};
				5'd30: {six_if_neg, six_if_pos, six_flip} = {6'b011110, 6'b100001, 1'b1};
				default: {six_if_neg, six_if_pos, six_flip} = {6'b101011, 6'b010100, 1'b1};
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// 3b/4b table

	always_comb begin
		if (tx_sym.is_ctl) begin
			// K28 balanced codes are swapped against the data ones
			case (three_b)
				3'd0: {four_if_neg, four_if_pos, four_flip} = {4'b1011, 4'b0100, 1'b1};
				3'd1: {four_if_neg, four_if_pos, four_flip} = {4'b0110, 4'b1001, 1'b0};
				3'd2: {four_if_neg, four_if_pos, four_flip} = {4'b1010, 4'b0101, 1'b0};
				3'd3: {four_if_neg, four_if_pos, four_flip} = {4'b1100, 4'b0011, 1'b0};
				3'd4: {four_if_neg, four_if_pos, four_flip} = {4'b1101, 4'b0010, 1'b1};
				3'd5: {four_if_neg, four_if_pos, four_flip} = {4'b0101, 4'b1010, 1'b0};
				3'd6: {four_if_neg, four_if_pos, four_flip} = {4'b1001, 4'b0110, 1'b0};
				default: {four_if_neg, four_if_pos, four_flip} = {4'b0111, 4'b1000, 1'b1};
			endcase
		end else begin
			case (three_b)
				3'd0: {four_if_neg, four_if_pos, four_flip} = {4'b1011, 4'b0100, 1'b1};
				3'd1: {four_if_neg, four_if_pos, four_flip} = {4'b1001, 4'b1001, 1'b0};
				3'd2: {four_if_neg, four_if_pos, four_flip} = {4'b0101, 4'b0101, 1'b0};
				3'd3: {four_if_neg, four_if_pos, four_flip} = {4'b1100, 4'b0011, 1'b0};
				3'd4: {four_if_neg, four_if_pos, four_flip} = {4'b1101, 4'b0010, 1'b1};
				3'd5: {four_if_neg, four_if_pos, four_flip} = {4'b1010, 4'b1010, 1'b0};
				3'd6: {four_if_neg, four_if_pos, four_flip} = {4'b0110, 4'b0110, 1'b0};
				default: begin
					// Primary D.x.P7
					{four_if_neg, four_if_pos, four_flip} = {4'b1110, 4'b0001, 1'b1};
					// A7 after these avoids a run of five that mimics a comma
					if (five_b inside {5'd17, 5'd18, 5'd20})
						four_if_neg = 4'b0111;
					if (five_b inside {5'd11, 5'd13, 5'd14})
						four_if_pos = 4'b1000;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sub-block select and disparity register

	// Force overrides the stored disparity for this symbol only
	assign start_neg = tx_disp_neg | force_disp_neg;
	assign disp_flip = six_flip ^ four_flip;

	always_comb begin
		if (start_neg) begin
			code_nxt.sb.six_b = six_if_neg;
			// Unbalanced 6b moves the 4b position to positive
			code_nxt.sb.four_b = six_flip ? four_if_pos : four_if_neg;
		end else begin
			code_nxt.sb.six_b = six_if_pos;
			code_nxt.sb.four_b = six_flip ? four_if_neg : four_if_pos;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_code.bits <= '0;
			tx_disp_neg <= 1'b1;
		end else begin
			tx_code <= code_nxt;
			// Disparity after this word
			tx_disp_neg <= start_neg ^ disp_flip;
		end
	end

endmodule

// File: rtl/line_code_pkg.sv
package line_code_pkg;

	//////////////////////////////////////////////////////////////////////
	// Symbols on either side of the line coder

	// Byte plus K flag going into the encoder
	typedef struct packed {
		logic is_ctl;
		// 7:5 is the 3b part, 4:0 the 5b part
		logic [7:0] data;
	} tx_symbol_t;

	// Decoded byte with error status
	typedef struct packed {
		logic is_ctl;
		logic [7:0] data;
		// Not a legal code group
		logic code_err;
		// Legal group, wrong running disparity
		logic disp_err;
	} rx_symbol_t;

	//////////////////////////////////////////////////////////////////////
	// Line codeword

	// abcdei sub-block sits above fghj
	typedef struct packed {
		logic [5:0] six_b;
		logic [3:0] four_b;
	} sub_block_t;

	// Same ten bits seen flat or as sub-blocks
	typedef union packed {
		logic [9:0] bits;
		sub_block_t sb;
	} codeword_t;

	//////////////////////////////////////////////////////////////////////
	// Control codes

	// Comma byte
	localparam logic [7:0] K28_5 = 8'hBC;

	// K28.5 sent from negative running disparity
	localparam logic [9:0] K28_5_RD_NEG = 10'b001111_1010;

endpackage

// File: rtl/line_coder.sv
`timescale 1ns/100ps

module line_coder import line_code_pkg::*; (
	input logic clk,
	input logic arst_n,
	// Transmit side
	input tx_symbol_t tx_sym,
	input logic force_disp_neg,
	output codeword_t tx_code,
	output logic tx_disp_neg,
	// Receive side
	input codeword_t rx_code,
	output rx_symbol_t rx_sym,
	output logic rx_disp_neg
);

	//////////////////////////////////////////////////////////////////////
	// Transmit half

	// One symbol coded per clock
	encode_8b10b enc0 (
		.clk(clk),
		.arst_n(arst_n),
		.tx_sym(tx_sym),
		.force_disp_neg(force_disp_neg),
		.tx_code(tx_code),
		.tx_disp_neg(tx_disp_neg)
	);

	//////////////////////////////////////////////////////////////////////
	// Receive half

	// Fed from outside so the link can be looped or corrupted
	decode_8b10b dec0 (
		.clk(clk),
		.arst_n(arst_n),
		.rx_code(rx_code),
		.rx_sym(rx_sym),
		.rx_disp_neg(rx_disp_neg)
	);

endmodule

// File: verification/line_coder_assert.sv
`timescale 1ns/100ps

module line_coder_assert import line_code_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic force_disp_neg,
	input codeword_t tx_code,
	input logic tx_disp_neg
);

	// Number of failed assertions
	int failures = 0;

	//////////////////////////////////////////////////////////////////////
	// Encoder output rules, from the second edge after reset

	// Four, five or six ones only
	weight_ok: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) |-> $countones(tx_code.bits) inside {4, 5, 6})
		else begin
			failures++;
			$error("tx_code weight outside 4 to 6");
		end

	// Six ones only from negative disparity, or when forced there
	six_after_neg: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) && $countones(tx_code.bits) == 6
		|-> $past(tx_disp_neg) || $past(force_disp_neg))
		else begin
			failures++;
			$error("tx_code with six ones after positive disparity");
		end

	// Unbalanced word flips the running disparity
	flip_on_unbalanced: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) && !$past(force_disp_neg)
		|-> (tx_disp_neg != $past(tx_disp_neg)) == ($countones(tx_code.bits) != 5))
		else begin
			failures++;
			$error("tx_disp_neg flip does not match tx_code balance");
		end

endmodule

bind line_coder line_coder_assert asrt0 (.*);

// File: verification/line_coder_tb.sv
`timescale 1ns/100ps

module line_coder_tb import line_code_pkg::*; ();

	logic clk = 1'b0;
	logic arst_n;
	tx_symbol_t tx_sym;
	logic force_disp_neg;
	codeword_t tx_code;
	logic tx_disp_neg;
	codeword_t rx_code;
	rx_symbol_t rx_sym;
	logic rx_disp_neg;

	// Chosen receive word, used when the loop is open
	codeword_t loop_code;
	logic loop_on;

	int errors = 0;
	int checks = 0;
	logic [31:0] lfsr = 32'h7d34_adfd;

	// Direct loop keeps tx_sym to rx_sym at two cycles
	assign rx_code = loop_on ? tx_code : loop_code;

	line_coder dut0 (.*);

	always #20 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic random_byte(output logic [7:0] b);
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_next(lfsr);
			b[k] = lfsr[0];
		end
	endtask

	task automatic apply_reset();
		int cycles;
		cycles = 0;
		@(posedge clk);
		arst_n <= 1'b0;
		@(negedge clk);
		// Async reset, levels should already be back
		while (tx_disp_neg !== 1'b1 || rx_disp_neg !== 1'b1) begin
			if (cycles == 4) begin
				errors++;
				$display("Timeout: disparity levels did not return to reset values");
				break;
			end
			cycles++;
			@(negedge clk);
		end
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_code(input string name, input codeword_t got, input codeword_t exp);
		checks++;
		if (got.bits !== exp.bits) begin
			errors++;
			$display("ERR %s: got 0x%h, expected 0x%h", name, got.bits, exp.bits);
		end
	endtask

	task automatic check_sym(input string name, input rx_symbol_t got, input rx_symbol_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Weight must fit the disparity ahead of the word
	task automatic check_word_disp(input logic prev_neg);
		int ones;
		logic exp_neg;
		ones = $countones(tx_code.bits);
		checks++;
		if (ones < 4 || ones > 6 || (ones == 6 && !prev_neg) || (ones == 4 && prev_neg)) begin
			errors++;
			$display("Codeword %b has %0d ones, not allowed after %s disparity",
				tx_code.bits, ones, prev_neg ? "negative" : "positive");
		end
		exp_neg = (ones == 6) ? 1'b0 : (ones == 4) ? 1'b1 : prev_neg;
		check_bit("tx_disp_neg", tx_disp_neg, exp_neg);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic reset_state();
		@(negedge clk);
		check_code("tx_code", tx_code, '0);
		check_bit("tx_disp_neg", tx_disp_neg, 1'b1);
		check_bit("rx_disp_neg", rx_disp_neg, 1'b1);
		check_sym("rx_sym", rx_sym, '0);
	endtask

	task automatic known_vector();
		codeword_t exp;
		@(posedge clk);
		tx_sym <= {1'b1, K28_5};
		force_disp_neg <= 1'b1;
		@(posedge clk);
		force_disp_neg <= 1'b0;
		@(negedge clk);
		exp.bits = K28_5_RD_NEG;
		check_code("tx_code", tx_code, exp);
		check_bit("tx_disp_neg", tx_disp_neg, 1'b0);
		// Same comma from positive disparity
		@(negedge clk);
		exp.bits = ~K28_5_RD_NEG;
		check_code("tx_code", tx_code, exp);
		check_bit("tx_disp_neg", tx_disp_neg, 1'b1);
	endtask

	task automatic loopback();
		tx_symbol_t sent[$];
		logic [7:0] k_seven [4];
		logic [7:0] b;
		logic prev_neg;
		int n;
		int i;
		k_seven = '{8'hF7, 8'hFB, 8'hFD, 8'hFE};
		// Forced comma lines up both ends
		sent.push_back({1'b1, K28_5});
		for (i = 0; i < 200; i++) begin
			random_byte(b);
			sent.push_back({1'b0, b});
		end
		for (i = 0; i < 8; i++)
			sent.push_back({1'b1, 3'(i), 5'd28});
		foreach (k_seven[j])
			sent.push_back({1'b1, k_seven[j]});
		n = sent.size();
		prev_neg = 1'b1;
		for (i = 0; i < n + 2; i++) begin
			@(posedge clk);
			loop_on <= 1'b1;
			if (i < n)
				tx_sym <= sent[i];
			force_disp_neg <= (i == 0);
			@(negedge clk);
			// Receive side trails transmit by one word
			if (i >= 2)
				check_bit("rx_disp_neg", rx_disp_neg, prev_neg);
			if (i >= 3)
				check_sym("rx_sym", rx_sym, {sent[i - 2].is_ctl, sent[i - 2].data, 2'b00});
			if (i >= 1)
				check_word_disp(prev_neg);
			prev_neg = (i == 0) ? 1'b1 : tx_disp_neg;
		end
	endtask

	task automatic code_error();
		@(posedge clk);
		loop_on <= 1'b0;
		loop_code <= '0;
		@(posedge clk);
		loop_code <= '1;
		@(negedge clk);
		check_bit("rx_sym.code_err", rx_sym.code_err, 1'b1);
		@(negedge clk);
		check_bit("rx_sym.code_err", rx_sym.code_err, 1'b1);
	endtask

	task automatic disp_error();
		rx_symbol_t exp;
		@(posedge clk);
		loop_on <= 1'b0;
		loop_code.bits <= K28_5_RD_NEG;
		apply_reset();
		// First decode lands on the edge after release
		repeat (2) @(negedge clk);
		exp = {1'b1, K28_5, 2'b00};
		check_sym("rx_sym", rx_sym, exp);
		@(negedge clk);
		exp.disp_err = 1'b1;
		check_sym("rx_sym", rx_sym, exp);
	endtask

	initial begin
		arst_n <= 1'b0;
		tx_sym <= '0;
		force_disp_neg <= 1'b0;
		loop_on <= 1'b0;
		loop_code <= '0;
		apply_reset();
		reset_state();
		known_vector();
		loopback();
		code_error();
		disp_error();
		// Bound assertion failures count as errors too
		errors += dut0.asrt0.failures;
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
